// File: tb/mem_stimulus.txt
// op addr store_data rt reg_we reg_id flush expected_data expected_byte_we
// op: 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 lwl 7 lwr 8 sb 9 sh a sw b swl c swr
// word stores then word loads.
a 00000010 11223344 09 0 00 0 00000010 0
a 00000014 a5b6c7d8 09 0 00 0 00000014 0
a 00000018 8081f00f 09 0 00 0 00000018 0
5 00000010 00000000 00 1 01 0 11223344 f
5 00000014 00000000 00 1 01 0 a5b6c7d8 f
5 00000018 00000000 00 1 01 0 8081f00f f
// byte and halfword loads.
1 00000014 00000000 00 1 01 0 ffffffd8 f
1 00000015 00000000 00 1 01 0 ffffffc7 f
1 00000016 00000000 00 1 01 0 ffffffb6 f
1 00000017 00000000 00 1 01 0 ffffffa5 f
2 00000014 00000000 00 1 01 0 000000d8 f
2 00000017 00000000 00 1 01 0 000000a5 f
1 00000018 00000000 00 1 01 0 0000000f f
3 00000014 00000000 00 1 01 0 ffffc7d8 f
3 00000010 00000000 00 1 01 0 00003344 f
4 00000016 00000000 00 1 01 0 0000a5b6 f
// partial stores checked by word loads.
a 00000020 11223344 09 0 00 0 00000020 0
a 00000024 11223344 09 0 00 0 00000024 0
a 00000028 11223344 09 0 00 0 00000028 0
8 00000021 000000aa 09 0 00 0 00000021 0
9 00000022 0000bbcc 09 0 00 0 00000022 0
5 00000020 00000000 00 1 01 0 bbccaa44 f
b 00000025 aabbccdd 09 0 00 0 00000025 0
5 00000024 00000000 00 1 01 0 1122aabb f
c 0000002a aabbccdd 09 0 00 0 0000002a 0
5 00000028 00000000 00 1 01 0 ccdd3344 f
// lwl and lwr with partial byte enables.
6 00000011 00000000 00 1 01 0 33440000 c
6 00000010 00000000 00 1 01 0 44000000 8
7 00000012 00000000 00 1 01 0 00001122 3
7 00000013 00000000 00 1 01 0 00000011 1
// store operand forwarding, and none through r0.
0 deadbeef 00000000 00 1 09 0 deadbeef f
a 00000030 00000000 09 0 00 0 00000030 0
5 00000030 00000000 00 1 01 0 deadbeef f
0 12345678 00000000 00 1 00 0 12345678 f
a 00000034 0000cafe 00 0 00 0 00000034 0
5 00000034 00000000 00 1 01 0 0000cafe f
// no register write, then flushed store and load.
0 00000abc 00000000 00 0 00 0 00000abc 0
a 00000038 55555555 09 0 00 1 00000000 0
5 00000038 00000000 00 1 01 0 00000000 f
5 00000010 00000000 00 1 01 1 00000000 0
5 00000010 00000000 00 1 01 0 11223344 f

// File: all.f
+incdir+source
source/mem_pkg.sv
source/store_align.sv
source/load_extend.sv
source/bus_master.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_subsystem.sv
tb/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/mem_pkg.sv
      - source/store_align.sv
      - source/load_extend.sv
      - source/bus_master.sv
      - source/mem_stage.sv
      - source/data_ram.sv
      - source/mem_subsystem.sv
  - target: test
    files:
      - tb/tb_mem_subsystem.sv

// File: tb/tb_mem_subsystem.sv
module tb_mem_subsystem;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 64;
    localparam int FIELDS       = 9;   // words per stimulus line.

    logic                Clk;
    logic                rst_n;
    logic                flush;
    mem_pkg::ex_bundle_t ex;
    mem_pkg::wb_bundle_t wb;
    logic                stall;

    logic [31:0] stim [0:MAX_LINES*FIELDS-1];
    int          line_count;
    int          cycle_limit;
    int          check_count;
    int          error_count;

    mem_subsystem DUT (
        .Clk   (Clk),
        .rst_n (rst_n),
        .flush (flush),
        .ex    (ex),
        .wb    (wb),
        .stall (stall)
    );

    always #2 Clk = ~Clk;

    // ####################
    // compare tasks.
    // ####################

    task automatic compare_word(input string name, input mem_pkg::word_t got,
                                input mem_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h.", $time, name, got, exp);
        end
    endtask

    task automatic compare_byte_en(input string name, input mem_pkg::byte_en_t got,
                                   input mem_pkg::byte_en_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at time %0t: %s is %b, expected %b.", $time, name, got, exp);
        end
    endtask

    task automatic compare_reg_id(input string name, input mem_pkg::reg_id_t got,
                                  input mem_pkg::reg_id_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h.", $time, name, got, exp);
        end
    endtask

    task automatic compare_stall_cycles(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("** Error at time %0t: %s is %0d cycles, expected %0d.",
                     $time, name, got, exp);
        end
    endtask

    // one execute bundle plus the flush flag from line n.
    task automatic drive_line(input int n);
        int base;
        base = n * FIELDS;
        ex.pc             = mem_pkg::word_t'(n * 4);
        ex.addr_or_result = stim[base + 1];
        ex.store_data     = stim[base + 2];
        ex.rt_id          = mem_pkg::reg_id_t'(stim[base + 3]);
        ex.mem_op         = mem_pkg::mem_op_e'(stim[base][3:0]);
        ex.reg_we         = stim[base + 4][0];
        ex.reg_id         = mem_pkg::reg_id_t'(stim[base + 5]);
        flush             = stim[base + 6][0];
    endtask

    // ####################
    // watchdog.
    // ####################

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge Clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles.", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int                stall_cycles;
        int                exp_stall;
        int                errors_before;
        int                base;
        mem_pkg::mem_op_e  line_op;
        mem_pkg::word_t    exp_pc;
        mem_pkg::reg_id_t  exp_reg_id;

        Clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        ex          = '0;
        check_count = 0;
        error_count = 0;
        line_count  = 0;
        cycle_limit = 0;

        $readmemh("tb/mem_stimulus.txt", stim);
        while (line_count < MAX_LINES && !$isunknown(stim[line_count * FIELDS])) begin
            line_count++;
        end
        if (line_count == 0) begin
            $display("no instructions were read from the stimulus file.");
            error_count++;
        end
        cycle_limit = RESET_CYCLES + 3 * line_count;

        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        rst_n = 1'b1;

        for (int n = 0; n < line_count; n++) begin
            base          = n * FIELDS;
            errors_before = error_count;
            line_op       = mem_pkg::mem_op_e'(stim[base][3:0]);
            // a memory op that is not flushed waits exactly one cycle for ack.
            exp_stall     = (stim[base][3:0] != 4'h0 && !stim[base + 6][0]) ? 1 : 0;
            // a flush clears the whole writeback register.
            exp_pc        = stim[base + 6][0] ? '0 : mem_pkg::word_t'(n * 4);
            exp_reg_id    = stim[base + 6][0] ? '0 : mem_pkg::reg_id_t'(stim[base + 5]);
            drive_line(n);
            stall_cycles = 0;
            @(negedge Clk);
            while (stall === 1'b1) begin
                stall_cycles++;
                @(negedge Clk);
            end
            @(posedge Clk);   // accepting edge.
            #1;
            compare_stall_cycles("stall", stall_cycles, exp_stall);
            compare_word("wb.pc", wb.pc, exp_pc);
            compare_reg_id("wb.reg_id", wb.reg_id, exp_reg_id);
            compare_word("wb.data", wb.data, stim[base + 7]);
            compare_byte_en("wb.reg_byte_we", wb.reg_byte_we,
                            mem_pkg::byte_en_t'(stim[base + 8]));
            $display("line %0d %s: %s", n, line_op.name(),
                     (error_count == errors_before) ? "ok" : "FAILED");
        end

        $display("%0d instructions, %0d checks, %0d errors.",
                 line_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: source/mem_subsystem.sv
module mem_subsystem (
    input  logic                Clk,
    input  logic                rst_n,
    input  logic                flush,
    input  mem_pkg::ex_bundle_t ex,
    output mem_pkg::wb_bundle_t wb,
    output logic                stall
);

    logic              cyc;
    logic              stb;
    logic              we;
    mem_pkg::word_t    adr;
    mem_pkg::word_t    dat_w;
    mem_pkg::byte_en_t sel;
    mem_pkg::word_t    dat_r;
    logic              ack;

    mem_stage u_mem_stage (
        .Clk   (Clk),
        .rst_n (rst_n),
        .flush (flush),
        .ex    (ex),
        .wb    (wb),
        .stall (stall),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .ack   (ack),
        .dat_r (dat_r)
    );

    data_ram u_data_ram (
        .Clk   (Clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

endmodule

// File: source/data_ram.sv
`include "mem_defs.svh"

module data_ram (
    input  logic              Clk,
    input  logic              rst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  mem_pkg::word_t    adr,
    input  mem_pkg::word_t    dat_w,
    input  mem_pkg::byte_en_t sel,
    output mem_pkg::word_t    dat_r,
    output logic              ack
);

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);

    mem_pkg::word_t   mem [0:`MEM_RAM_WORDS-1] = '{default: '0};
    logic [IDX_W-1:0] idx;
    logic             req;

    assign idx = adr[IDX_W+1:2];
    assign req = cyc && stb;

    // one wait state then a single ack cycle.
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req && !ack;
        end
    end

    always_ff @(posedge Clk) begin
        if (req && !ack) begin
            dat_r <= mem[idx];
        end
        if (req && we && ack) begin   // commit only in the ack cycle.
            for (int b = 0; b < `MEM_DATA_W/8; b++) begin
                if (sel[b]) begin
                    mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: source/mem_stage.sv
module mem_stage (
    input  logic                Clk,
    input  logic                rst_n,
    input  logic                flush,
    input  mem_pkg::ex_bundle_t ex,
    output mem_pkg::wb_bundle_t wb,
    output logic                stall,
    output logic                cyc,
    output logic                stb,
    output logic                we,
    output mem_pkg::word_t      adr,
    output mem_pkg::word_t      dat_w,
    output mem_pkg::byte_en_t   sel,
    input  logic                ack,
    input  mem_pkg::word_t      dat_r
);

    logic                fwd_hit;
    mem_pkg::word_t      store_opnd;
    logic [1:0]          offset;
    mem_pkg::word_t      st_wdata;
    mem_pkg::byte_en_t   st_sel;
    mem_pkg::word_t      ld_data;
    mem_pkg::byte_en_t   ld_byte_we;
    mem_pkg::wb_bundle_t wb_next;

    // rt written by the instruction now in writeback.
    assign fwd_hit    = ex.rt_id != '0 && ex.rt_id == wb.reg_id && |wb.reg_byte_we;
    assign store_opnd = fwd_hit ? wb.data : ex.store_data;
    assign offset     = ex.addr_or_result[1:0];

    store_align u_store_align (
        .op     (ex.mem_op),
        .offset (offset),
        .data   (store_opnd),
        .wdata  (st_wdata),
        .sel    (st_sel)
    );

    bus_master u_bus_master (
        .Clk   (Clk),
        .rst_n (rst_n),
        .flush (flush),
        .op    (ex.mem_op),
        .addr  (ex.addr_or_result),
        .wdata (st_wdata),
        .sel   (st_sel),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .bsel  (sel),
        .ack   (ack),
        .stall (stall)
    );

    load_extend u_load_extend (
        .raw      (dat_r),
        .offset   (offset),
        .op       (ex.mem_op),
        .passthru (ex.addr_or_result),  // alu result for non-loads.
        .reg_we   (ex.reg_we),
        .data     (ld_data),
        .byte_we  (ld_byte_we)
    );

    always_comb begin
        wb_next.pc          = ex.pc;
        wb_next.reg_byte_we = ld_byte_we;
        wb_next.reg_id      = ex.reg_id;
        wb_next.data        = ld_data;
    end

    // ####################
    // writeback register.

    always_ff @(posedge Clk) begin
        if (!rst_n || flush) begin
            wb <= '0;
        end else if (!stall) begin
            wb <= wb_next;
        end
    end

    // the execute stage holds its bundle until the access completes.
    a_ex_hold: assert property (@(posedge Clk) disable iff (!rst_n)
        stall && !flush |=> $stable(ex));

endmodule

// File: source/bus_master.sv
module bus_master (
    input  logic              Clk,
    input  logic              rst_n,
    input  logic              flush,
    input  mem_pkg::mem_op_e  op,
    input  mem_pkg::word_t    addr,
    input  mem_pkg::word_t    wdata,
    input  mem_pkg::byte_en_t sel,
    output logic              cyc,
    output logic              stb,
    output logic              we,
    output mem_pkg::word_t    adr,
    output mem_pkg::word_t    dat_w,
    output mem_pkg::byte_en_t bsel,
    input  logic              ack,
    output logic              stall
);

    typedef enum logic {
        st_idle,
        st_wait_ack
    } state_e;

    state_e state;
    logic   is_load;
    logic   is_store;
    logic   ack_ok;

    assign is_load = op inside {mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_lh,
                                mem_pkg::op_lhu, mem_pkg::op_lw, mem_pkg::op_lwl,
                                mem_pkg::op_lwr};
    assign is_store = op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw,
                                 mem_pkg::op_swl, mem_pkg::op_swr};

    // request follows the current bundle directly.
    assign cyc   = (is_load || is_store) && !flush;
    assign stb   = cyc;
    assign we    = cyc && is_store;
    assign adr   = {addr[31:2], 2'b00};  // word address.
    assign dat_w = wdata;
    assign bsel  = sel;

    assign ack_ok = ack && state == st_wait_ack;  // only an ack for our own request.
    assign stall  = cyc && !ack_ok;

    always_ff @(posedge Clk) begin
        if (!rst_n || flush) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (cyc) begin
                        state <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ####################
    // wishbone checks.

    a_ack_needs_stb: assert property (@(posedge Clk) disable iff (!rst_n)
        ack && !flush |-> stb);

    a_hold_until_ack: assert property (@(posedge Clk) disable iff (!rst_n)
        stb && !ack_ok && !flush |=> flush || (stb && $stable(adr) && $stable(we)));

endmodule

// File: source/load_extend.sv
`include "mem_defs.svh"

module load_extend (
    input  mem_pkg::word_t    raw,
    input  logic [1:0]        offset,
    input  mem_pkg::mem_op_e  op,
    input  mem_pkg::word_t    passthru,
    input  logic              reg_we,
    output mem_pkg::word_t    data,
    output mem_pkg::byte_en_t byte_we
);

    mem_pkg::word_t    lane_word;
    logic [7:0]        lane_byte;
    logic [15:0]       lane_half;
    mem_pkg::byte_en_t lane_we;

    assign lane_word = raw >> {offset, 3'b000};
    assign lane_byte = lane_word[7:0];
    assign lane_half = offset[1] ? raw[31:16] : raw[15:0];

    always_comb begin
        data    = passthru;
        lane_we = 4'b1111;
        case (op)
            mem_pkg::op_lb:  data = {{(`MEM_DATA_W-8){lane_byte[7]}}, lane_byte};
            mem_pkg::op_lbu: data = {{(`MEM_DATA_W-8){1'b0}}, lane_byte};
            mem_pkg::op_lh:  data = {{(`MEM_DATA_W-16){lane_half[15]}}, lane_half};
            mem_pkg::op_lhu: data = {{(`MEM_DATA_W-16){1'b0}}, lane_half};
            mem_pkg::op_lw:  data = raw;
            // partial loads only replace some register bytes.
            mem_pkg::op_lwl: begin
                data    = raw << {~offset, 3'b000};
                lane_we = 4'b1111 << ~offset;
            end
            mem_pkg::op_lwr: begin
                data    = raw >> {offset, 3'b000};
                lane_we = 4'b1111 >> offset;
            end
            default: begin
            end
        endcase
    end

    assign byte_we = reg_we ? lane_we : 4'b0000;

    always_comb begin
        if (op == mem_pkg::op_lh || op == mem_pkg::op_lhu) begin
            a_half_aligned: assert final (offset[0] == 1'b0)
                else $error("halfword load from an odd address.");
        end
    end

endmodule

// File: source/store_align.sv
module store_align (
    input  mem_pkg::mem_op_e  op,
    input  logic [1:0]        offset,
    input  mem_pkg::word_t    data,
    output mem_pkg::word_t    wdata,
    output mem_pkg::byte_en_t sel
);

    logic [4:0] lane_shift;
    logic [4:0] left_shift;

    assign lane_shift = {offset, 3'b000};
    assign left_shift = {~offset, 3'b000};  // (3 - offset) bytes.

    always_comb begin
        wdata = data;     // sw and loads use the word as is.
        sel   = 4'b1111;
        case (op)
            mem_pkg::op_sb: begin
                wdata = data << lane_shift;
                sel   = 4'b0001 << offset;
            end
            mem_pkg::op_sh: begin
                wdata = data << {offset[1], 4'b0000};
                sel   = offset[1] ? 4'b1100 : 4'b0011;
            end
            // upper register bytes land in the low lanes.
            mem_pkg::op_swl: begin
                wdata = data >> left_shift;
                sel   = 4'b1111 >> ~offset;
            end
            mem_pkg::op_swr: begin
                wdata = data << lane_shift;
                sel   = 4'b1111 << offset;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: source/mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0]   word_t;
    typedef logic [`MEM_REG_ID_W-1:0] reg_id_t;   // index 0 is the zero register.
    typedef logic [`MEM_DATA_W/8-1:0] byte_en_t;  // one bit per byte lane.

    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_sb,
        op_sh,
        op_sw,
        op_swl,
        op_swr
    } mem_op_e;

    // bundle handed over by the execute stage.
    typedef struct packed {
        word_t   pc;
        word_t   addr_or_result;   // alu result, the address for memory ops.
        word_t   store_data;
        reg_id_t rt_id;
        mem_op_e mem_op;
        logic    reg_we;
        reg_id_t reg_id;
    } ex_bundle_t;

    // bundle registered for writeback.
    typedef struct packed {
        word_t    pc;
        byte_en_t reg_byte_we;     // zero when nothing is written.
        reg_id_t  reg_id;
        word_t    data;
    } wb_bundle_t;

endpackage

// File: source/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ####################
// datapath widths.
// ####################

`define MEM_DATA_W 32

// five bits address the 32 general registers.
`define MEM_REG_ID_W 5

// ####################
// data memory.
// ####################

`define MEM_RAM_WORDS 256

`endif
